// ==== logic/csr_cfg.svh ====
//--------------------------------------------------------------------------
// Machine CSR configuration
// Data width, CSR addresses, status bit positions and trap base reset
//--------------------------------------------------------------------------
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// Machine word width
`define XLEN 64

// Machine-mode CSR addresses
`define CSR_MSTATUS 12'h300
`define CSR_MIE     12'h304
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342
`define CSR_MIP     12'h344

// Bit positions in mstatus, mie and mip
`define MSTATUS_MIE_BIT  3
`define MSTATUS_MPIE_BIT 7
`define MSTATUS_MPP_LSB  11
`define MIE_MTIE_BIT     7
`define MIP_MTIP_BIT     7

// Trap base after reset, direct mode
`define MTVEC_RESET 64'h0000_0000_8000_0000

`endif

// ==== logic/trap_pkg.sv ====
//--------------------------------------------------------------------------
// Trap types
// Supported mcause values and trap event kinds
//--------------------------------------------------------------------------
`default_nettype none

`include "csr_cfg.svh"

package trap_pkg;

    // Interrupt flag in the top bit, code in the low bits
    typedef enum logic [`XLEN-1:0] {
        CAUSE_BREAKPOINT  = {{(`XLEN-4){1'b0}}, 4'd3},
        CAUSE_ECALL_M     = {{(`XLEN-4){1'b0}}, 4'd11},
        CAUSE_M_TIMER_IRQ = {1'b1, {(`XLEN-5){1'b0}}, 4'd7}
    } cause_e;

    // Update presented to the register file for one cycle
    typedef enum logic [1:0] {
        TRAP_NONE  = 2'd0,
        TRAP_ENTER = 2'd1,
        TRAP_RET   = 2'd2
    } trap_kind_e;

endpackage

`default_nettype wire

// ==== logic/csr_types_pkg.sv ====
//--------------------------------------------------------------------------
// CSR instruction types
// Operation encoding and the two views of the mstatus word
//--------------------------------------------------------------------------
`default_nettype none

`include "csr_cfg.svh"

package csr_types_pkg;

    // Follows funct3 of the SYSTEM opcode
    // Bit 2 marks the immediate form
    typedef enum logic [2:0] {
        CSR_OP_WRITE     = 3'b001,
        CSR_OP_SET       = 3'b010,
        CSR_OP_CLEAR     = 3'b011,
        CSR_OP_WRITE_IMM = 3'b101,
        CSR_OP_SET_IMM   = 3'b110,
        CSR_OP_CLEAR_IMM = 3'b111
    } csr_op_e;

    // Named mstatus fields, MSB first
    // Reserved gaps are sized from the bit positions
    typedef struct packed {
        logic [`XLEN-`MSTATUS_MPP_LSB-3:0]                    rsv_hi;
        logic [1:0]                                           mpp;
        logic [`MSTATUS_MPP_LSB-`MSTATUS_MPIE_BIT-2:0]        rsv_mid;
        logic                                                 mpie;
        logic [`MSTATUS_MPIE_BIT-`MSTATUS_MIE_BIT-2:0]        rsv_lo;
        logic                                                 mie;
        logic [`MSTATUS_MIE_BIT-1:0]                          rsv_low;
    } mstatus_fields_t;

    // Raw word for CSR instructions, fields for trap updates
    typedef union packed {
        logic [`XLEN-1:0] raw;
        mstatus_fields_t  f;
    } mstatus_u;

endpackage

`default_nettype wire

// ==== logic/csr_regfile.sv ====
//--------------------------------------------------------------------------
// Machine CSR register file
// Six machine CSRs with software write port and trap update port
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "csr_cfg.svh"

module csr_regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wen,
    input  logic [11:0]            waddr,
    input  logic [`XLEN-1:0]       wdata,
    input  logic [11:0]            raddr,
    output logic [`XLEN-1:0]       rdata,
    input  trap_pkg::trap_kind_e   trap_kind,
    input  trap_pkg::cause_e       trap_cause,
    input  logic [`XLEN-1:0]       trap_epc,
    input  logic                   timer_irq,
    output logic                   mstatus_mie,
    output logic                   mtie,
    output logic [`XLEN-1:0]       mtvec,
    output logic [`XLEN-1:0]       mepc
);

    import trap_pkg::*;
    import csr_types_pkg::*;

    mstatus_u         mstatus;
    logic [`XLEN-1:0] mie;
    logic [`XLEN-1:0] mip;
    logic [`XLEN-1:0] mcause;
    logic             sw_we;

    // Trap updates win over a software write in the same cycle
    assign sw_we = wen && (trap_kind == TRAP_NONE);

    //----------------------------------------------------------------------
    // Read mux
    //----------------------------------------------------------------------
    // One-hot AND-OR select, unknown address reads zero
    assign rdata = {`XLEN{raddr == `CSR_MSTATUS}} & mstatus.raw |
                   {`XLEN{raddr == `CSR_MIE}}     & mie         |
                   {`XLEN{raddr == `CSR_MIP}}     & mip         |
                   {`XLEN{raddr == `CSR_MTVEC}}   & mtvec       |
                   {`XLEN{raddr == `CSR_MEPC}}    & mepc        |
                   {`XLEN{raddr == `CSR_MCAUSE}}  & mcause;

    //----------------------------------------------------------------------
    // mstatus
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus.raw <= '0;
        end else if (trap_kind == TRAP_ENTER) begin
            // Stack interrupt enable, stay in M-mode
            mstatus.f.mpie <= mstatus.f.mie;
            mstatus.f.mie  <= 1'b0;
            mstatus.f.mpp  <= 2'b11;
        end else if (trap_kind == TRAP_RET) begin
            // Pop interrupt enable
            mstatus.f.mie  <= mstatus.f.mpie;
            mstatus.f.mpie <= 1'b1;
        end else if (sw_we && waddr == `CSR_MSTATUS) begin
            mstatus.raw <= wdata;
        end
    end

    //----------------------------------------------------------------------
    // Trap state registers
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc   <= '0;
            mcause <= '0;
        end else if (trap_kind == TRAP_ENTER) begin
            mepc   <= trap_epc;
            mcause <= trap_cause;
        end else begin
            if (sw_we && waddr == `CSR_MEPC) begin
                mepc <= wdata;
            end
            if (sw_we && waddr == `CSR_MCAUSE) begin
                mcause <= wdata;
            end
        end
    end

    // Trap base and interrupt enables, software only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec <= `MTVEC_RESET;
            mie   <= '0;
        end else begin
            if (sw_we && waddr == `CSR_MTVEC) begin
                mtvec <= wdata;
            end
            if (sw_we && waddr == `CSR_MIE) begin
                mie <= wdata;
            end
        end
    end

    // Pending bits, MTIP follows the timer line every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mip <= '0;
        end else begin
            if (sw_we && waddr == `CSR_MIP) begin
                mip <= wdata;
            end
            mip[`MIP_MTIP_BIT] <= timer_irq;
        end
    end

    // Enables seen by the trap controller
    assign mstatus_mie = mstatus.f.mie;
    assign mtie        = mie[`MIE_MTIE_BIT];

endmodule

`default_nettype wire

// ==== logic/csr_op_unit.sv ====
//--------------------------------------------------------------------------
// CSR instruction unit
// Four-phase req/ack front end doing one CSR read-modify-write
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "csr_cfg.svh"

module csr_op_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   op_req,
    input  csr_types_pkg::csr_op_e op,
    input  logic [11:0]            csr_addr,
    input  logic [`XLEN-1:0]       src,
    output logic                   op_ack,
    output logic [`XLEN-1:0]       old_value,
    output logic [11:0]            raddr,
    input  logic [`XLEN-1:0]       rdata,
    input  logic                   trap_hold,
    output logic                   wen,
    output logic [11:0]            waddr,
    output logic [`XLEN-1:0]       wdata
);

    import csr_types_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_ACK
    } state_e;

    state_e           state;
    logic             accept;
    logic             do_write;
    logic [`XLEN-1:0] operand;

    // Request taken on this edge unless a trap update is in flight
    assign accept = (state == ST_IDLE) && op_req && !trap_hold;

    //----------------------------------------------------------------------
    // Read-modify-write datapath
    //----------------------------------------------------------------------
    // Immediate forms use only the 5-bit zimm
    assign operand = op[2] ? {{(`XLEN-5){1'b0}}, src[4:0]} : src;

    always_comb begin
        wdata    = operand;
        do_write = 1'b0;
        case (op)
            CSR_OP_WRITE, CSR_OP_WRITE_IMM: begin
                wdata    = operand;
                do_write = 1'b1;
            end
            CSR_OP_SET, CSR_OP_SET_IMM: begin
                wdata    = rdata | operand;
                // No write side effect for a zero mask
                do_write = |operand;
            end
            CSR_OP_CLEAR, CSR_OP_CLEAR_IMM: begin
                wdata    = rdata & ~operand;
                do_write = |operand;
            end
            default: begin
                do_write = 1'b0;
            end
        endcase
    end

    // Read by address, write lands on the accepting edge
    assign raddr = csr_addr;
    assign waddr = csr_addr;
    assign wen   = accept && do_write;

    //----------------------------------------------------------------------
    // Handshake FSM
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (accept) state <= ST_ACK;
                ST_ACK:  if (!op_req) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Value before the operation, returned with the ack
    always_ff @(posedge clk) begin
        if (accept) begin
            old_value <= rdata;
        end
    end

    assign op_ack = (state == ST_ACK);

endmodule

`default_nettype wire

// ==== logic/trap_ctrl.sv ====
//--------------------------------------------------------------------------
// Trap controller
// Picks trap entry or return, drives the CSR update and the redirect
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "csr_cfg.svh"

module trap_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 exc_valid,
    input  trap_pkg::cause_e     exc_cause,
    input  logic [`XLEN-1:0]     exc_pc,
    input  logic                 mret_valid,
    input  logic                 timer_irq,
    input  logic [`XLEN-1:0]     irq_pc,
    input  logic                 mstatus_mie,
    input  logic                 mtie,
    input  logic [`XLEN-1:0]     mtvec,
    input  logic [`XLEN-1:0]     mepc,
    output trap_pkg::trap_kind_e trap_kind,
    output trap_pkg::cause_e     trap_cause,
    output logic [`XLEN-1:0]     trap_epc,
    output logic                 trap_hold,
    output logic                 redirect_valid,
    output logic [`XLEN-1:0]     redirect_pc
);

    import trap_pkg::*;

    trap_kind_e       next_kind;
    cause_e           next_cause;
    logic [`XLEN-1:0] next_epc;
    logic [`XLEN-1:0] next_target;
    logic             irq_take;

    // No re-entry while the previous update is still pending
    assign irq_take = timer_irq && mstatus_mie && mtie && (trap_kind == TRAP_NONE);

    //----------------------------------------------------------------------
    // Event priority, exception then mret then timer
    //----------------------------------------------------------------------
    always_comb begin
        next_kind   = TRAP_NONE;
        next_cause  = exc_cause;
        next_epc    = exc_pc;
        // Direct mode only, mode bits dropped
        next_target = {mtvec[`XLEN-1:2], 2'b00};
        if (exc_valid) begin
            next_kind = TRAP_ENTER;
        end else if (mret_valid) begin
            next_kind   = TRAP_RET;
            next_target = mepc;
        end else if (irq_take) begin
            next_kind  = TRAP_ENTER;
            next_cause = CAUSE_M_TIMER_IRQ;
            next_epc   = irq_pc;
        end
    end

    // Stall CSR instructions from sampling through update
    assign trap_hold = (next_kind != TRAP_NONE) || (trap_kind != TRAP_NONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trap_kind      <= TRAP_NONE;
            redirect_valid <= 1'b0;
        end else begin
            trap_kind      <= next_kind;
            redirect_valid <= (next_kind != TRAP_NONE);
        end
    end

    // Event payload, valid alongside trap_kind
    always_ff @(posedge clk) begin
        if (next_kind != TRAP_NONE) begin
            trap_cause  <= next_cause;
            trap_epc    <= next_epc;
            redirect_pc <= next_target;
        end
    end

endmodule

`default_nettype wire

// ==== logic/csr_subsystem.sv ====
//--------------------------------------------------------------------------
// Machine-mode CSR subsystem
// CSR instruction unit, trap controller and register file
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "csr_cfg.svh"

module csr_subsystem (
    input  logic                   clk,
    input  logic                   rst_n,
    // Pipeline CSR handshake
    input  logic                   op_req,
    input  csr_types_pkg::csr_op_e op,
    input  logic [11:0]            csr_addr,
    input  logic [`XLEN-1:0]       src,
    output logic                   op_ack,
    output logic [`XLEN-1:0]       old_value,
    // Trap events
    input  logic                   exc_valid,
    input  trap_pkg::cause_e       exc_cause,
    input  logic [`XLEN-1:0]       exc_pc,
    input  logic                   mret_valid,
    input  logic                   timer_irq,
    input  logic [`XLEN-1:0]       irq_pc,
    output logic                   redirect_valid,
    output logic [`XLEN-1:0]       redirect_pc
);

    import trap_pkg::*;

    logic             wen;
    logic [11:0]      waddr;
    logic [`XLEN-1:0] wdata;
    logic [11:0]      raddr;
    logic [`XLEN-1:0] rdata;
    trap_kind_e       trap_kind;
    cause_e           trap_cause;
    logic [`XLEN-1:0] trap_epc;
    logic             trap_hold;
    logic             mstatus_mie;
    logic             mtie;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mepc;

    csr_op_unit i_op_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_req    (op_req),
        .op        (op),
        .csr_addr  (csr_addr),
        .src       (src),
        .op_ack    (op_ack),
        .old_value (old_value),
        .raddr     (raddr),
        .rdata     (rdata),
        .trap_hold (trap_hold),
        .wen       (wen),
        .waddr     (waddr),
        .wdata     (wdata)
    );

    trap_ctrl i_trap_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .exc_valid      (exc_valid),
        .exc_cause      (exc_cause),
        .exc_pc         (exc_pc),
        .mret_valid     (mret_valid),
        .timer_irq      (timer_irq),
        .irq_pc         (irq_pc),
        .mstatus_mie    (mstatus_mie),
        .mtie           (mtie),
        .mtvec          (mtvec),
        .mepc           (mepc),
        .trap_kind      (trap_kind),
        .trap_cause     (trap_cause),
        .trap_epc       (trap_epc),
        .trap_hold      (trap_hold),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    csr_regfile i_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .wen         (wen),
        .waddr       (waddr),
        .wdata       (wdata),
        .raddr       (raddr),
        .rdata       (rdata),
        .trap_kind   (trap_kind),
        .trap_cause  (trap_cause),
        .trap_epc    (trap_epc),
        .timer_irq   (timer_irq),
        .mstatus_mie (mstatus_mie),
        .mtie        (mtie),
        .mtvec       (mtvec),
        .mepc        (mepc)
    );

endmodule

`default_nettype wire

// ==== verif/csr_tb.sv ====
//--------------------------------------------------------------------------
// Machine CSR subsystem testbench
// Reference CSR model, handshake and trap stimulus, compare and watchdog
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "csr_cfg.svh"

module csr_tb;

    import csr_types_pkg::*;
    import trap_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int NUM_RANDOM_OPS  = 200;
    localparam int NUM_OPS         = NUM_RANDOM_OPS + 50;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 10 + 100;
    localparam int ACK_LIMIT       = 20;

    // Address outside the implemented set
    localparam logic [11:0] UNKNOWN_ADDR = 12'h7c0;

    // Model slots, slot 7 stands for any unknown address and stays zero
    localparam logic [2:0] SLOT_MSTATUS = 3'd0;
    localparam logic [2:0] SLOT_MIE     = 3'd1;
    localparam logic [2:0] SLOT_MIP     = 3'd2;
    localparam logic [2:0] SLOT_MTVEC   = 3'd3;
    localparam logic [2:0] SLOT_MEPC    = 3'd4;
    localparam logic [2:0] SLOT_MCAUSE  = 3'd5;
    localparam logic [2:0] SLOT_NONE    = 3'd7;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             op_req;
    csr_op_e          op;
    logic [11:0]      csr_addr;
    logic [`XLEN-1:0] src;
    logic             op_ack;
    logic [`XLEN-1:0] old_value;
    logic             exc_valid;
    cause_e           exc_cause;
    logic [`XLEN-1:0] exc_pc;
    logic             mret_valid;
    logic             timer_irq;
    logic [`XLEN-1:0] irq_pc;
    logic             redirect_valid;
    logic [`XLEN-1:0] redirect_pc;

    integer           seed = 32'h3fd;
    logic [`XLEN-1:0] model_csr [8];
    logic             timer_level;
    logic             ack_seen = 1'b0;

    // Expectations, in the order the DUT answers them
    logic [`XLEN-1:0] exp_old [$];
    logic [11:0]      exp_addr [$];
    logic [`XLEN-1:0] exp_redirect [$];

    csr_subsystem i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .op_req         (op_req),
        .op             (op),
        .csr_addr       (csr_addr),
        .src            (src),
        .op_ack         (op_ack),
        .old_value      (old_value),
        .exc_valid      (exc_valid),
        .exc_cause      (exc_cause),
        .exc_pc         (exc_pc),
        .mret_valid     (mret_valid),
        .timer_irq      (timer_irq),
        .irq_pc         (irq_pc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //----------------------------------------------------------------------
    // Failure reporting and compare tasks
    //----------------------------------------------------------------------
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [`XLEN-1:0] got,
                               input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Error at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_redirect(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Error at %0t: redirect_pc got %h expected %h",
                                     $time, got, exp));
        end
    endtask

    //----------------------------------------------------------------------
    // Reference model
    //----------------------------------------------------------------------
    function automatic logic [2:0] csr_slot(input logic [11:0] addr);
        case (addr)
            `CSR_MSTATUS: return SLOT_MSTATUS;
            `CSR_MIE:     return SLOT_MIE;
            `CSR_MIP:     return SLOT_MIP;
            `CSR_MTVEC:   return SLOT_MTVEC;
            `CSR_MEPC:    return SLOT_MEPC;
            `CSR_MCAUSE:  return SLOT_MCAUSE;
            default:      return SLOT_NONE;
        endcase
    endfunction

    // Applies one CSR instruction, returns the value before it
    function automatic logic [`XLEN-1:0] model_apply_op(input csr_op_e kind,
                                                        input logic [11:0] addr,
                                                        input logic [`XLEN-1:0] operand);
        logic [2:0]       slot;
        logic [`XLEN-1:0] cur;
        logic [`XLEN-1:0] nxt;
        logic             writes;
        slot = csr_slot(addr);
        cur  = model_csr[slot];
        case (kind)
            CSR_OP_WRITE, CSR_OP_WRITE_IMM: begin
                nxt    = operand;
                writes = 1'b1;
            end
            CSR_OP_SET, CSR_OP_SET_IMM: begin
                nxt    = cur | operand;
                writes = |operand;
            end
            default: begin
                nxt    = cur & ~operand;
                writes = |operand;
            end
        endcase
        if (writes && slot != SLOT_NONE) begin
            model_csr[slot] = nxt;
        end
        // Timer pending bit is owned by the timer line
        model_csr[SLOT_MIP][`MIP_MTIP_BIT] = timer_level;
        return cur;
    endfunction

    // Applies trap entry or return, returns the redirect target
    function automatic logic [`XLEN-1:0] model_trap(input trap_kind_e kind,
                                                    input cause_e cause,
                                                    input logic [`XLEN-1:0] epc);
        mstatus_u         st;
        logic [`XLEN-1:0] target;
        st.raw = model_csr[SLOT_MSTATUS];
        if (kind == TRAP_ENTER) begin
            target                  = {model_csr[SLOT_MTVEC][`XLEN-1:2], 2'b00};
            model_csr[SLOT_MEPC]    = epc;
            model_csr[SLOT_MCAUSE]  = cause;
            st.f.mpie               = st.f.mie;
            st.f.mie                = 1'b0;
            st.f.mpp                = 2'b11;
        end else begin
            target    = model_csr[SLOT_MEPC];
            st.f.mie  = st.f.mpie;
            st.f.mpie = 1'b1;
        end
        model_csr[SLOT_MSTATUS] = st.raw;
        return target;
    endfunction

    //----------------------------------------------------------------------
    // Compare process
    //----------------------------------------------------------------------
    always @(posedge clk) begin
        ack_seen <= op_ack;
        if (op_ack && !ack_seen) begin
            if (exp_old.size() == 0) begin
                report_failure("op_ack rose while no request was outstanding");
            end else begin
                check_value($sformatf("old_value (csr %h)", exp_addr.pop_front()),
                            old_value, exp_old.pop_front());
            end
        end
        if (redirect_valid) begin
            if (exp_redirect.size() == 0) begin
                report_failure("redirect_valid pulsed although no trap was expected");
            end else begin
                check_redirect(redirect_pc, exp_redirect.pop_front());
            end
        end
    end

    //----------------------------------------------------------------------
    // Stimulus tasks, each starts and ends just after a rising edge
    //----------------------------------------------------------------------
    function automatic csr_op_e pick_op(input int n);
        case (n)
            0:       return CSR_OP_WRITE;
            1:       return CSR_OP_SET;
            2:       return CSR_OP_CLEAR;
            3:       return CSR_OP_WRITE_IMM;
            4:       return CSR_OP_SET_IMM;
            default: return CSR_OP_CLEAR_IMM;
        endcase
    endfunction

    function automatic logic [11:0] pick_addr(input int n);
        case (n)
            0:       return `CSR_MSTATUS;
            1:       return `CSR_MIE;
            2:       return `CSR_MIP;
            3:       return `CSR_MTVEC;
            4:       return `CSR_MEPC;
            5:       return `CSR_MCAUSE;
            default: return UNKNOWN_ADDR;
        endcase
    endfunction

    task automatic start_op(input csr_op_e kind, input logic [11:0] addr,
                            input logic [`XLEN-1:0] value);
        op_req   <= 1'b1;
        op       <= kind;
        csr_addr <= addr;
        src      <= value;
        exp_addr.push_back(addr);
        exp_old.push_back(model_apply_op(kind, addr, value));
    endtask

    // Ack must rise after exactly rise_edges edges, fall one cycle after release
    task automatic finish_op(input int rise_edges);
        int n;
        @(posedge clk);
        n = 1;
        while (!op_ack && n < ACK_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!op_ack) begin
            report_failure("op_ack never rose for a pending request");
        end
        if (n != rise_edges) begin
            report_failure($sformatf("Error at %0t: op_ack latency got %0d expected %0d",
                                     $time, n, rise_edges));
        end
        op_req <= 1'b0;
        @(posedge clk);
        if (!op_ack) begin
            report_failure("op_ack fell before op_req was sampled low");
        end
        @(posedge clk);
        if (op_ack) begin
            report_failure("op_ack still high one cycle after op_req was sampled low");
        end
    endtask

    task automatic issue_op(input csr_op_e kind, input logic [11:0] addr,
                            input logic [`XLEN-1:0] value);
        start_op(kind, addr, value);
        finish_op(2);
    endtask

    // csrrs with x0, no write side effect
    task automatic read_csr(input logic [11:0] addr);
        issue_op(CSR_OP_SET, addr, '0);
    endtask

    task automatic read_all();
        for (int k = 0; k < 7; k++) begin
            read_csr(pick_addr(k));
        end
    endtask

    task automatic pulse_event(input trap_kind_e kind, input cause_e cause,
                               input logic [`XLEN-1:0] pc);
        if (kind == TRAP_ENTER) begin
            exc_valid <= 1'b1;
            exc_cause <= cause;
            exc_pc    <= pc;
        end else begin
            mret_valid <= 1'b1;
        end
        exp_redirect.push_back(model_trap(kind, cause, pc));
        @(posedge clk);
        exc_valid  <= 1'b0;
        mret_valid <= 1'b0;
        if (redirect_valid) begin
            report_failure("redirect_valid rose in the same cycle as the event");
        end
        @(posedge clk);
        if (!redirect_valid) begin
            report_failure("redirect_valid did not follow the event by one cycle");
        end
        @(posedge clk);
    endtask

    task automatic set_timer(input logic level);
        timer_irq   <= level;
        timer_level = level;
        model_csr[SLOT_MIP][`MIP_MTIP_BIT] = level;
        // Let mip pick up the new level
        repeat (2) @(posedge clk);
    endtask

    // Sampling and update cycles hold the request, then the normal ack
    task automatic op_during_exception(input cause_e cause, input logic [`XLEN-1:0] pc);
        exc_valid <= 1'b1;
        exc_cause <= cause;
        exc_pc    <= pc;
        exp_redirect.push_back(model_trap(TRAP_ENTER, cause, pc));
        start_op(CSR_OP_SET_IMM, `CSR_MSTATUS, 64'd8);
        @(posedge clk);
        exc_valid <= 1'b0;
        finish_op(3);
    endtask

    //----------------------------------------------------------------------
    // Test sequence
    //----------------------------------------------------------------------
    initial begin
        csr_op_e          kind;
        logic [11:0]      addr;
        logic [`XLEN-1:0] value;
        logic [`XLEN-1:0] pc;
        rst_n       = 1'b0;
        op_req      = 1'b0;
        op          = CSR_OP_WRITE;
        csr_addr    = '0;
        src         = '0;
        exc_valid   = 1'b0;
        exc_cause   = CAUSE_ECALL_M;
        exc_pc      = '0;
        mret_valid  = 1'b0;
        timer_irq   = 1'b0;
        irq_pc      = '0;
        timer_level = 1'b0;
        model_csr   = '{default: '0};
        model_csr[SLOT_MTVEC] = `MTVEC_RESET;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // Reset values
        read_all();

        // Random register and immediate forms, some with a zero operand
        for (int i = 0; i < NUM_RANDOM_OPS; i++) begin
            kind  = pick_op($unsigned($random(seed)) % 6);
            addr  = pick_addr($unsigned($random(seed)) % 7);
            value = {$random(seed), $random(seed)};
            if (kind inside {CSR_OP_WRITE_IMM, CSR_OP_SET_IMM, CSR_OP_CLEAR_IMM}) begin
                value = {{(`XLEN-5){1'b0}}, value[4:0]};
            end
            if ($unsigned($random(seed)) % 8 == 0) begin
                value = '0;
            end
            issue_op(kind, addr, value);
        end
        read_all();

        // Exception entry from MIE set, mode bits in mtvec
        value = {$random(seed), $random(seed)} | 64'h3;
        issue_op(CSR_OP_WRITE, `CSR_MTVEC, value);
        issue_op(CSR_OP_WRITE, `CSR_MSTATUS, 64'h8);
        pc = {$random(seed), $random(seed)};
        pulse_event(TRAP_ENTER, CAUSE_ECALL_M, pc);
        read_csr(`CSR_MEPC);
        read_csr(`CSR_MCAUSE);
        read_csr(`CSR_MSTATUS);
        pulse_event(TRAP_RET, CAUSE_ECALL_M, '0);
        read_csr(`CSR_MSTATUS);

        // Breakpoint with MIE already clear
        issue_op(CSR_OP_CLEAR_IMM, `CSR_MSTATUS, 64'd8);
        pc = {$random(seed), $random(seed)};
        pulse_event(TRAP_ENTER, CAUSE_BREAKPOINT, pc);
        read_csr(`CSR_MCAUSE);
        read_csr(`CSR_MSTATUS);
        pulse_event(TRAP_RET, CAUSE_ECALL_M, '0);
        read_csr(`CSR_MSTATUS);

        //------------------------------------------------------------------
        // Timer interrupt
        //------------------------------------------------------------------
        issue_op(CSR_OP_WRITE, `CSR_MSTATUS, '0);
        issue_op(CSR_OP_WRITE, `CSR_MIE, 64'h80);
        pc = {$random(seed), $random(seed)};
        irq_pc <= pc;
        set_timer(1'b1);
        // Pending and enabled in mie, but MIE clear
        repeat (8) @(posedge clk);
        read_csr(`CSR_MIP);
        start_op(CSR_OP_SET_IMM, `CSR_MSTATUS, 64'd8);
        exp_redirect.push_back(model_trap(TRAP_ENTER, CAUSE_M_TIMER_IRQ, pc));
        finish_op(2);
        read_csr(`CSR_MEPC);
        read_csr(`CSR_MCAUSE);
        read_csr(`CSR_MSTATUS);
        // Entry cleared MIE, no second entry while the line stays high
        repeat (8) @(posedge clk);
        set_timer(1'b0);
        pulse_event(TRAP_RET, CAUSE_ECALL_M, '0);
        read_csr(`CSR_MSTATUS);

        // Request raised with an exception sees the post-trap mstatus
        pc = {$random(seed), $random(seed)};
        op_during_exception(CAUSE_BREAKPOINT, pc);
        read_csr(`CSR_MEPC);
        read_all();

        repeat (2) @(posedge clk);
        if (exp_old.size() != 0 || exp_redirect.size() != 0) begin
            report_failure("Some expected acks or redirects were never seen");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

    // Watchdog sized from the number of operations
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure($sformatf("Timeout: run still busy after %0d cycles",
                                 WATCHDOG_CYCLES));
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+logic
logic/trap_pkg.sv
logic/csr_types_pkg.sv
logic/csr_regfile.sv
logic/csr_op_unit.sv
logic/trap_ctrl.sv
logic/csr_subsystem.sv
verif/csr_tb.sv

// ==== Makefile ====
# Verilator build and run of the machine CSR subsystem testbench

VERILATOR ?= verilator
TOP       ?= csr_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timescale 1ns/100ps
PASS_MSG  ?= TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run, pass if '$(PASS_MSG)' is printed"
	@echo "  clean  remove the build directory $(OBJ_DIR)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
